// File: common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

   // **********************************************************
   // Cache geometry
   // **********************************************************

   // Operand and address widths of the load/store unit
   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;

   // Byte offset inside a 32-bit word
   localparam int BYTE_W = 2;
   // Word select inside a 16-byte block
   localparam int WORD_W = 2;
   // Set index, 16 sets in the direct-mapped array
   localparam int INDEX_W = 4;
   // Everything above the index is tag
   localparam int TAG_W = ADDR_W - INDEX_W - WORD_W - BYTE_W;

   localparam int WORDS_PER_BLOCK = 1 << WORD_W;
   localparam int NUM_SETS = 1 << INDEX_W;
   // One select bit per byte lane of a word
   localparam int BSEL_W = DATA_W / 8;

   // **********************************************************
   // Address decode
   // **********************************************************

   // Field layout of a byte address, most significant field first
   typedef struct packed {
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] index;
      logic [WORD_W-1:0]  word;
      logic [BYTE_W-1:0]  boff;
   } addr_fields_t;

   // The ports and the memory carry the raw word
   // The stores and the controller look at the fields
   typedef union packed {
      logic [ADDR_W-1:0] raw;
      addr_fields_t      f;
   } addr_u;

   // **********************************************************
   // Bundles between blocks
   // **********************************************************

   // One CPU load or store, held stable until ack or err
   typedef struct packed {
      logic              we;
      addr_u             adr;
      logic [DATA_W-1:0] wdat;
      logic [BSEL_W-1:0] bsel;
   } cpu_req_t;

   // Per-set bookkeeping in the tag store
   typedef struct packed {
      logic             dirty;
      logic             valid;
      logic [TAG_W-1:0] tag;
   } tag_entry_t;

   // One word of a victim dump toward memory
   typedef struct packed {
      addr_u             adr;
      logic [DATA_W-1:0] dat;
   } mem_wr_t;

endpackage

`default_nettype wire

// File: dcache/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
   input  wire logic                          clk,
   input  wire logic                          rst,
   // CPU side
   input  wire logic                          cpu_req_i,
   input  wire dcache_pkg::cpu_req_t          cpu_req_i_data,
   output logic                               cpu_ack_o,
   output logic                               cpu_err_o,
   output logic [dcache_pkg::DATA_W-1:0]      cpu_rdat_o,
   // Memory side
   output logic                               mem_rd_req_o,
   output dcache_pkg::addr_u                  mem_rd_adr_o,
   input  wire logic                          mem_rvalid_i,
   input  wire logic [dcache_pkg::DATA_W-1:0] mem_rdat_i,
   input  wire logic                          mem_err_i,
   output logic                               mem_wr_o,
   output dcache_pkg::mem_wr_t                mem_wr_o_data,
   // Tag store
   output dcache_pkg::addr_u                  lookup_adr_o,
   input  wire logic                          hit_i,
   input  wire dcache_pkg::tag_entry_t        victim_i,
   output logic                               tag_we_o,
   output dcache_pkg::tag_entry_t             tag_wdata_o,
   // Data store
   input  wire logic [dcache_pkg::DATA_W-1:0] rdat_i,
   output logic [dcache_pkg::WORD_W-1:0]      data_rd_word_o,
   output logic                               data_we_o,
   output logic [dcache_pkg::WORD_W-1:0]      data_wr_word_o,
   output logic [dcache_pkg::DATA_W-1:0]      data_wdat_o,
   output logic [dcache_pkg::BSEL_W-1:0]      data_bsel_o
);

   typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_DUMP, ST_REFILL} state_t;

   state_t                          state_q;
   // Word counter shared by dump and refill, both run from word 0
   logic [dcache_pkg::WORD_W-1:0]   cnt_q;
   logic                            err_q;
   dcache_pkg::cpu_req_t            req_q;
   logic [dcache_pkg::TAG_W-1:0]    victim_tag_q;
   logic                            victim_dirty;
   logic                            last_word;

   // Only a valid block with modified data needs to go back to memory
   assign victim_dirty = victim_i.valid & victim_i.dirty;
   assign last_word    = (cnt_q == dcache_pkg::WORD_W'(dcache_pkg::WORDS_PER_BLOCK - 1));

   // **********************************************************
   // State sequencing
   // **********************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
         err_q   <= 1'b0;
      end else begin
         err_q <= 1'b0;
         case (state_q)
            // The request seen while err is pulsing is the one that failed
            ST_IDLE: if (cpu_req_i && !err_q) state_q <= ST_LOOKUP;
            ST_LOOKUP: begin
               cnt_q <= '0;
               if (hit_i) state_q <= ST_IDLE;
               else if (victim_dirty) state_q <= ST_DUMP;
               else state_q <= ST_REFILL;
            end
            // One victim word per cycle, no back-pressure from memory
            ST_DUMP: begin
               cnt_q <= cnt_q + 1'b1;
               if (last_word) state_q <= ST_REFILL;
            end
            ST_REFILL: begin
               if (mem_err_i) begin
                  err_q   <= 1'b1;
                  state_q <= ST_IDLE;
               end else if (mem_rvalid_i) begin
                  cnt_q <= cnt_q + 1'b1;
                  // Replay the lookup, which now hits
                  if (last_word) state_q <= ST_LOOKUP;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Capture the request as it arrives and the victim tag when the lookup misses
   always_ff @(posedge clk) begin
      if (state_q == ST_IDLE && cpu_req_i) req_q <= cpu_req_i_data;
      if (state_q == ST_LOOKUP && !hit_i) victim_tag_q <= victim_i.tag;
   end

   // **********************************************************
   // Store control
   // **********************************************************
   always_comb begin
      tag_we_o       = 1'b0;
      tag_wdata_o    = victim_i;
      data_we_o      = 1'b0;
      data_wr_word_o = req_q.adr.f.word;
      data_wdat_o    = req_q.wdat;
      data_bsel_o    = req_q.bsel;
      case (state_q)
         ST_LOOKUP: begin
            if (hit_i && req_q.we) begin
               // Byte lanes are merged inside the data store
               data_we_o         = 1'b1;
               tag_we_o          = 1'b1;
               tag_wdata_o.dirty = 1'b1;
            end else if (!hit_i && !victim_dirty) begin
               // Clean victim, drop it before the refill overwrites it
               tag_we_o    = 1'b1;
               tag_wdata_o = '{dirty: 1'b0, valid: 1'b0, tag: req_q.adr.f.tag};
            end
         end
         ST_DUMP: begin
            // The last dump word has been read, the set is free
            if (last_word) begin
               tag_we_o    = 1'b1;
               tag_wdata_o = '{dirty: 1'b0, valid: 1'b0, tag: req_q.adr.f.tag};
            end
         end
         ST_REFILL: begin
            if (mem_rvalid_i && !mem_err_i) begin
               data_we_o      = 1'b1;
               data_wr_word_o = cnt_q;
               data_wdat_o    = mem_rdat_i;
               data_bsel_o    = '1;
               // Fresh block is valid and matches memory
               if (last_word) begin
                  tag_we_o    = 1'b1;
                  tag_wdata_o = '{dirty: 1'b0, valid: 1'b1, tag: req_q.adr.f.tag};
               end
            end
         end
         default: ;
      endcase
   end

   assign lookup_adr_o   = req_q.adr;
   // The dump walks the block, every other state reads the requested word
   assign data_rd_word_o = (state_q == ST_DUMP) ? cnt_q : req_q.adr.f.word;

   // **********************************************************
   // Port outputs
   // **********************************************************
   assign cpu_ack_o    = (state_q == ST_LOOKUP) & hit_i;
   assign cpu_err_o    = err_q;
   assign cpu_rdat_o   = rdat_i;
   assign mem_rd_req_o = (state_q == ST_REFILL);
   assign mem_wr_o     = (state_q == ST_DUMP);

   always_comb begin
      mem_rd_adr_o.f.tag   = req_q.adr.f.tag;
      mem_rd_adr_o.f.index = req_q.adr.f.index;
      mem_rd_adr_o.f.word  = '0;
      mem_rd_adr_o.f.boff  = '0;
      // The victim shares the index of the request
      mem_wr_o_data.adr.f.tag   = victim_tag_q;
      mem_wr_o_data.adr.f.index = req_q.adr.f.index;
      mem_wr_o_data.adr.f.word  = cnt_q;
      mem_wr_o_data.adr.f.boff  = '0;
      mem_wr_o_data.dat         = rdat_i;
   end

   // The registered error never lands in a lookup cycle
   a_ack_err_excl: assert property (@(posedge clk) disable iff (rst)
      !(cpu_ack_o && cpu_err_o));
   // A dump strobe only carries a modified block that the request misses
   a_wr_in_dump: assert property (@(posedge clk) disable iff (rst)
      mem_wr_o |-> victim_dirty && !hit_i);
   // The refill only starts once the set holds no modified data
   a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
      mem_rd_req_o |-> !victim_dirty);

endmodule

`default_nettype wire

// File: dcache/dcache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_store (
   input  wire logic                           clk,
   input  wire logic [dcache_pkg::INDEX_W-1:0] index_i,
   input  wire logic [dcache_pkg::WORD_W-1:0]  rd_word_i,
   output logic [dcache_pkg::DATA_W-1:0]       rdat_o,
   input  wire logic                           we_i,
   input  wire logic [dcache_pkg::WORD_W-1:0]  wr_word_i,
   input  wire logic [dcache_pkg::DATA_W-1:0]  wdat_i,
   input  wire logic [dcache_pkg::BSEL_W-1:0]  bsel_i
);

   localparam int DEPTH = dcache_pkg::NUM_SETS * dcache_pkg::WORDS_PER_BLOCK;
   localparam int AW    = dcache_pkg::INDEX_W + dcache_pkg::WORD_W;

   // Flat word array, addressed by set and word
   logic [dcache_pkg::DATA_W-1:0] mem_q [DEPTH];
   logic [AW-1:0]                 rd_adr;
   logic [AW-1:0]                 wr_adr;

   // Read and write share the set, only the word differs
   assign rd_adr = {index_i, rd_word_i};
   assign wr_adr = {index_i, wr_word_i};

   // **********************************************************
   // Byte-lane write
   // **********************************************************

   // Lanes that are not selected keep their old byte
   always_ff @(posedge clk) begin
      if (we_i) begin
         for (int b = 0; b < dcache_pkg::BSEL_W; b++) begin
            if (bsel_i[b]) mem_q[wr_adr][b*8 +: 8] <= wdat_i[b*8 +: 8];
         end
      end
   end

   // Asynchronous read, used both for CPU loads and for the victim dump
   assign rdat_o = mem_q[rd_adr];

   // A write without any lane means the controller picked the wrong selects
   a_bsel_nonzero: assert property (@(posedge clk)
      we_i |-> (bsel_i != '0));

endmodule

`default_nettype wire

// File: dcache/dcache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire dcache_pkg::addr_u      lookup_adr_i,
   input  wire logic                   tag_we_i,
   input  wire dcache_pkg::tag_entry_t tag_wdata_i,
   output logic                        hit_o,
   output dcache_pkg::tag_entry_t      victim_o
);

   // One entry per set, direct mapped
   dcache_pkg::tag_entry_t tags_q [dcache_pkg::NUM_SETS];
   dcache_pkg::tag_entry_t entry;

   // **********************************************************
   // Array update
   // **********************************************************

   // Reset clears every valid and dirty bit
   // A write replaces the whole entry of the indexed set
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
            tags_q[s].valid <= 1'b0;
            tags_q[s].dirty <= 1'b0;
         end
      end else if (tag_we_i) begin
         tags_q[lookup_adr_i.f.index] <= tag_wdata_i;
      end
   end

   // **********************************************************
   // Lookup
   // **********************************************************

   // Read is combinational so the controller decides in the same cycle
   assign entry = tags_q[lookup_adr_i.f.index];

   // A hit needs both a live entry and a matching upper address
   assign hit_o = entry.valid && (entry.tag == lookup_adr_i.f.tag);

   // On a miss this entry is the block to be replaced
   assign victim_o = entry;

   // A write at an unknown set would corrupt an arbitrary entry
   a_known_index: assert property (@(posedge clk) disable iff (rst)
      tag_we_i |-> !$isunknown(lookup_adr_i.f.index));

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
   input  wire logic                          clk,
   input  wire logic                          rst,
   // CPU port, one request held until ack or err
   input  wire logic                          cpu_req_i,
   input  wire dcache_pkg::cpu_req_t          cpu_req_i_data,
   output logic                               cpu_ack_o,
   output logic                               cpu_err_o,
   output logic [dcache_pkg::DATA_W-1:0]      cpu_rdat_o,
   // Memory port, level read request and strobed dump writes
   output logic                               mem_rd_req_o,
   output dcache_pkg::addr_u                  mem_rd_adr_o,
   input  wire logic                          mem_rvalid_i,
   input  wire logic [dcache_pkg::DATA_W-1:0] mem_rdat_i,
   input  wire logic                          mem_err_i,
   output logic                               mem_wr_o,
   output dcache_pkg::mem_wr_t                mem_wr_o_data
);

   dcache_pkg::addr_u             lookup_adr;
   logic                          hit;
   dcache_pkg::tag_entry_t        victim;
   logic                          tag_we;
   dcache_pkg::tag_entry_t        tag_wdata;
   logic [dcache_pkg::DATA_W-1:0] rdat;
   logic [dcache_pkg::WORD_W-1:0] data_rd_word;
   logic                          data_we;
   logic [dcache_pkg::WORD_W-1:0] data_wr_word;
   logic [dcache_pkg::DATA_W-1:0] data_wdat;
   logic [dcache_pkg::BSEL_W-1:0] data_bsel;

   // **********************************************************
   // Controller and the two stores
   // **********************************************************
   dcache_ctrl u_ctrl (
      .clk, .rst, .cpu_req_i, .cpu_req_i_data, .cpu_ack_o, .cpu_err_o, .cpu_rdat_o,
      .mem_rd_req_o, .mem_rd_adr_o, .mem_rvalid_i, .mem_rdat_i, .mem_err_i,
      .mem_wr_o, .mem_wr_o_data,
      .lookup_adr_o(lookup_adr), .hit_i(hit), .victim_i(victim),
      .tag_we_o(tag_we), .tag_wdata_o(tag_wdata), .rdat_i(rdat),
      .data_rd_word_o(data_rd_word), .data_we_o(data_we), .data_wr_word_o(data_wr_word),
      .data_wdat_o(data_wdat), .data_bsel_o(data_bsel)
   );

   dcache_tag_store u_tags (
      .clk, .rst, .lookup_adr_i(lookup_adr), .tag_we_i(tag_we), .tag_wdata_i(tag_wdata),
      .hit_o(hit), .victim_o(victim)
   );

   // The data store only needs the set index of the lookup address
   dcache_data_store u_data (
      .clk, .index_i(lookup_adr.f.index), .rd_word_i(data_rd_word), .rdat_o(rdat),
      .we_i(data_we), .wr_word_i(data_wr_word), .wdat_i(data_wdat), .bsel_i(data_bsel)
   );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module dcache_tb -f verilog.f -o Vdcache_tb

./obj_dir/Vdcache_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi
exit 0

// File: verification/dcache_tb_checks.svh
`ifndef DCACHE_TB_CHECKS_SVH
`define DCACHE_TB_CHECKS_SVH

// **********************************************************
// Result counters and compare tasks
// **********************************************************

// Every compare bumps check_cnt, every mismatch bumps err_cnt
int check_cnt = 0;
int err_cnt = 0;

// Compares one data word, an address or a small count
task automatic check_word(input string name,
                          input logic [dcache_pkg::DATA_W-1:0] exp,
                          input logic [dcache_pkg::DATA_W-1:0] act);
   check_cnt++;
   if (act !== exp) begin
      err_cnt++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
   end
endtask

// Compares one dump strobe, address and data together
task automatic check_mem_wr(input string name,
                            input dcache_pkg::mem_wr_t exp,
                            input dcache_pkg::mem_wr_t act);
   check_cnt++;
   if (act !== exp) begin
      err_cnt++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
   end
endtask

// A failure that has no expected value, described in words
task automatic report_failure(input string what);
   err_cnt++;
   $display("%s", what);
endtask

`endif

// File: verification/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

   `include "dcache_tb_checks.svh"

   localparam int CLK_NS = 4;
   // Upper bound on requests issued by the whole sequence
   localparam int NUM_OPS = 620;
   localparam int WATCHDOG_NS = NUM_OPS * (2 + 4 + 4 * 4 + 4) * CLK_NS + 2000;
   // Four tags times 16 sets times 4 words
   localparam int MEM_WORDS = 256;

   logic clk;
   logic rst;
   logic cpu_req_i;
   dcache_pkg::cpu_req_t cpu_req_i_data;
   logic cpu_ack_o;
   logic cpu_err_o;
   logic [31:0] cpu_rdat_o;
   logic mem_rd_req_o;
   dcache_pkg::addr_u mem_rd_adr_o;
   logic mem_rvalid_i;
   logic [31:0] mem_rdat_i;
   logic mem_err_i;
   logic mem_wr_o;
   dcache_pkg::mem_wr_t mem_wr_o_data;

   // Memory contents and the word values the CPU should see
   logic [31:0] backing [MEM_WORDS];
   logic [31:0] golden [MEM_WORDS];
   // Reference copy of the tag state, tag kept as a 2-bit selector
   logic m_valid [16];
   logic m_dirty [16];
   logic [1:0] m_tsel [16];

   logic [31:0] lcg_state;
   // Request under way, shared with the memory processes
   logic [1:0] op_tsel;
   logic [3:0] op_idx;
   int dump_cnt;
   logic inject_err;

   dcache_top dut (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // Linear congruential generator, upper bits are the better ones
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return {lcg_state[31:16], lcg_state[15:0] ^ lcg_state[31:16]};
   endfunction

   // Depends on every address bit so misplaced words show up
   function automatic logic [31:0] init_word(input int a);
      return 32'h1F2E3D4C ^ (a * 32'h9E3779B1) ^ (32'(a) << 24);
   endfunction

   function automatic logic [23:0] tag_of(input logic [1:0] tsel);
      return 24'h5A0000 + 24'(tsel) * 24'h001111;
   endfunction

   function automatic dcache_pkg::addr_u make_adr(input logic [1:0] tsel,
                                                  input logic [3:0] idx,
                                                  input logic [1:0] word);
      dcache_pkg::addr_u a;
      a.f.tag = tag_of(tsel);
      a.f.index = idx;
      a.f.word = word;
      a.f.boff = 2'b00;
      return a;
   endfunction

   // **********************************************************
   // Memory model
   // **********************************************************

   // Every dump strobe must carry the golden word of the victim
   initial begin
      dcache_pkg::mem_wr_t exp;
      forever begin
         @(negedge clk);
         if (mem_wr_o) begin
            exp.adr = make_adr(m_tsel[op_idx], op_idx, dump_cnt[1:0]);
            exp.dat = golden[{m_tsel[op_idx], op_idx, dump_cnt[1:0]}];
            check_mem_wr("dump strobe", exp, mem_wr_o_data);
            backing[{m_tsel[op_idx], op_idx, dump_cnt[1:0]}] = mem_wr_o_data.dat;
            dump_cnt++;
         end
      end
   end

   // Refill answers with 0 to 3 idle cycles before each word
   initial begin
      int gap;
      logic stop;
      forever begin
         @(negedge clk);
         if (mem_rd_req_o) begin
            check_word("refill address", make_adr(op_tsel, op_idx, 2'd0), mem_rd_adr_o);
            stop = 1'b0;
            for (int w = 0; w < 4 && !stop; w++) begin
               gap = int'(next_rand() % 4);
               repeat (gap) @(negedge clk);
               if (inject_err && w == 2) begin
                  mem_err_i = 1'b1;
                  @(negedge clk);
                  mem_err_i = 1'b0;
                  inject_err = 1'b0;
                  stop = 1'b1;
               end else begin
                  mem_rvalid_i = 1'b1;
                  mem_rdat_i = backing[{op_tsel, op_idx, 2'(w)}];
                  @(negedge clk);
                  mem_rvalid_i = 1'b0;
               end
            end
         end
      end
   end

   // **********************************************************
   // One CPU request, checked against the reference state
   // **********************************************************
   task automatic do_op(input string name, input logic we, input logic [1:0] tsel,
                        input logic [3:0] idx, input logic [1:0] word,
                        input logic [31:0] wdat, input logic [3:0] bsel,
                        input logic expect_err);
      logic hit_exp;
      int dumps_exp;
      int cycles;
      logic rd_seen;
      logic [7:0] gi;
      hit_exp = m_valid[idx] && (m_tsel[idx] == tsel);
      dumps_exp = (!hit_exp && m_valid[idx] && m_dirty[idx]) ? 4 : 0;
      gi = {tsel, idx, word};
      op_tsel = tsel;
      op_idx = idx;
      dump_cnt = 0;
      rd_seen = 1'b0;
      cycles = 0;
      @(negedge clk);
      cpu_req_i = 1'b1;
      cpu_req_i_data.we = we;
      cpu_req_i_data.adr = make_adr(tsel, idx, word);
      cpu_req_i_data.wdat = wdat;
      cpu_req_i_data.bsel = bsel;
      forever begin
         @(negedge clk);
         cycles++;
         if (mem_rd_req_o) rd_seen = 1'b1;
         if (cpu_ack_o || cpu_err_o || cycles > 200) break;
      end
      cpu_req_i = 1'b0;
      if (!cpu_ack_o && !cpu_err_o) begin
         report_failure({name, ": no ack or error within 200 cycles"});
      end else if (expect_err) begin
         if (!cpu_err_o) report_failure({name, ": bus error was not reported to the CPU"});
         m_valid[idx] = 1'b0;
         m_dirty[idx] = 1'b0;
      end else if (cpu_err_o) begin
         report_failure({name, ": unexpected error response"});
      end else begin
         if (!we) check_word({name, " read data"}, golden[gi], cpu_rdat_o);
         if (hit_exp) begin
            check_word({name, " hit latency"}, 32'd1, 32'(cycles));
            if (rd_seen) report_failure({name, ": hit raised a memory read request"});
         end
         // Byte lanes merged into the CPU view
         for (int b = 0; b < 4; b++) begin
            if (we && bsel[b]) golden[gi][b*8 +: 8] = wdat[b*8 +: 8];
         end
         m_valid[idx] = 1'b1;
         m_tsel[idx] = tsel;
         m_dirty[idx] = we | (hit_exp & m_dirty[idx]);
      end
      check_word({name, " dump count"}, 32'(dumps_exp), 32'(dump_cnt));
   endtask

   task automatic end_test(input string name, input int errs_before);
      $display("Test %s finished with %0d errors", name, err_cnt - errs_before);
   endtask

   // Stops a run that hangs anywhere
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the test sequence finished");
      $display("Result: FAILED");
      $finish;
   end

   // **********************************************************
   // Test sequence
   // **********************************************************
   initial begin
      int e0;
      logic [31:0] r;
      logic [3:0] bs;
      lcg_state = 32'd71;
      rst = 1'b1;
      cpu_req_i = 1'b0;
      cpu_req_i_data = '0;
      mem_rvalid_i = 1'b0;
      mem_rdat_i = '0;
      mem_err_i = 1'b0;
      inject_err = 1'b0;
      op_tsel = '0;
      op_idx = '0;
      dump_cnt = 0;
      for (int a = 0; a < MEM_WORDS; a++) begin
         backing[a] = init_word(a);
         golden[a] = init_word(a);
      end
      for (int s = 0; s < 16; s++) begin
         m_valid[s] = 1'b0;
         m_dirty[s] = 1'b0;
         m_tsel[s] = '0;
      end
      repeat (5) @(negedge clk);
      rst = 1'b0;

      e0 = err_cnt;
      if (cpu_ack_o || cpu_err_o || mem_rd_req_o || mem_wr_o)
         report_failure("An output strobe is high right after reset");
      for (int s = 0; s < 16; s++) begin
         for (int w = 0; w < 4; w++) do_op("reset read", 1'b0, 2'd0, 4'(s), 2'(w), '0, '0, 1'b0);
      end
      end_test("reset", e0);

      e0 = err_cnt;
      for (int s = 0; s < 16; s++) do_op("read hit", 1'b0, 2'd0, 4'(s), 2'(s), '0, '0, 1'b0);
      end_test("read hit", e0);

      e0 = err_cnt;
      for (int i = 0; i < 16; i++) begin
         r = next_rand();
         bs = r[3:0] == 4'd0 ? 4'b0001 : r[3:0];
         do_op("merge write", 1'b1, r[5:4], r[9:6], r[11:10], next_rand(), bs, 1'b0);
         do_op("merge read", 1'b0, r[5:4], r[9:6], r[11:10], '0, '0, 1'b0);
      end
      end_test("write merge", e0);

      // Dirty victim, then clean victim, then a hit on the refilled block
      e0 = err_cnt;
      for (int s = 0; s < 4; s++) begin
         do_op("evict dirty", 1'b1, 2'd1, 4'(s), 2'd2, next_rand(), 4'hF, 1'b0);
         do_op("evict read", 1'b0, 2'd2, 4'(s), 2'd1, '0, '0, 1'b0);
         do_op("evict clean", 1'b0, 2'd3, 4'(s), 2'd3, '0, '0, 1'b0);
      end
      end_test("eviction", e0);

      e0 = err_cnt;
      do_op("err setup", 1'b1, 2'd2, 4'd5, 2'd0, next_rand(), 4'hC, 1'b0);
      inject_err = 1'b1;
      do_op("bus error", 1'b0, 2'd3, 4'd5, 2'd1, '0, '0, 1'b1);
      do_op("err retry", 1'b0, 2'd3, 4'd5, 2'd1, '0, '0, 1'b0);
      end_test("bus error", e0);

      e0 = err_cnt;
      for (int i = 0; i < 400; i++) begin
         r = next_rand();
         bs = r[15:12] == 4'd0 ? 4'b1000 : r[15:12];
         do_op("random", r[0], r[2:1], r[6:3], r[8:7], next_rand(), bs, 1'b0);
      end
      end_test("random mix", e0);

      $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verification
common/dcache_pkg.sv
dcache/dcache_tag_store.sv
dcache/dcache_data_store.sv
dcache/dcache_ctrl.sv
hw/dcache_top.sv
verification/dcache_tb.sv
